//--- Bender.yml
package:
  name: store_queue

sources:
  - include_dirs:
      - .
    files:
      - sq_pkg.sv
      - sq_ptr_counter.sv
      - sq_entry_array.sv
      - sq_drain_fsm.sv
      - sq_stbuf_format.sv
      - sq_fwd_unit.sv
      - store_queue.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_store_queue.sv

//--- sq_consts.svh
// store queue constants

`ifndef SQ_CONSTS_SVH
`define SQ_CONSTS_SVH

// queue geometry
`define SQ_DEPTH    8
`define SQ_PTR_W    3
`define SQ_CNT_W    4

// address and data
`define SQ_ADDR_W   32
`define SQ_DATA_W   64
`define SQ_BYTES    8
`define SQ_OFS_W    3

`endif

//--- sq_drain_fsm.sv
// store queue drain sequencer
`timescale 1ns/1ps
`default_nettype none

module sq_drain_fsm
  import sq_pkg::*;
(
  input  wire logic i_clk,
  input  wire logic i_reset_n,
  input  wire logic i_commit_pending,
  input  wire logic i_stbuf_ack,
  output logic      o_issue,
  output logic      o_release
);

  sq_drain_state_e r_state;
  sq_drain_state_e state_nxt;

  // one store buffer request in flight at a time
  always_comb begin
    o_issue   = 1'b0;
    o_release = 1'b0;
    state_nxt = r_state;
    case (r_state)
      DRAIN_IDLE: begin
        if (i_commit_pending) begin
          o_issue   = 1'b1;
          state_nxt = DRAIN_WAIT;
        end
      end
      DRAIN_WAIT: begin
        // ack frees the head at this edge
        if (i_stbuf_ack) begin
          o_release = 1'b1;
          state_nxt = DRAIN_IDLE;
        end
      end
      default: begin
        state_nxt = DRAIN_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= DRAIN_IDLE;
    end else begin
      r_state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

//--- sq_entry_array.sv
// store queue entry storage
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module sq_entry_array
  import sq_pkg::*;
(
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire logic                 i_alloc_en,
  input  wire sq_alloc_t            i_alloc,
  input  wire logic [`SQ_PTR_W-1:0] i_tail_ptr,
  input  wire logic [`SQ_PTR_W-1:0] i_commit_ptr,
  input  wire logic                 i_commit_en,
  input  wire logic                 i_release,
  input  wire logic [`SQ_PTR_W-1:0] i_head_ptr,
  output sq_entry_vec_t             o_entries,
  output sq_entry_t                 o_head_entry
);

  logic [`SQ_DEPTH-1:0]  r_valid;
  logic [`SQ_DEPTH-1:0]  r_committed;
  sq_addr_u              r_addr [`SQ_DEPTH];
  sq_size_e              r_size [`SQ_DEPTH];
  logic [`SQ_DATA_W-1:0] r_data [`SQ_DEPTH];

  // entry state flags
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      r_committed <= '0;
    end else begin
      if (i_release) begin
        r_valid[i_head_ptr]     <= 1'b0;
        r_committed[i_head_ptr] <= 1'b0;
      end
      if (i_commit_en) begin
        r_committed[i_commit_ptr] <= 1'b1;
      end
      if (i_alloc_en) begin
        r_valid[i_tail_ptr]     <= 1'b1;
        r_committed[i_tail_ptr] <= 1'b0;
      end
    end
  end

  // store payload
  always_ff @(posedge i_clk) begin
    if (i_alloc_en) begin
      r_addr[i_tail_ptr] <= i_alloc.addr;
      r_size[i_tail_ptr] <= i_alloc.size;
      r_data[i_tail_ptr] <= i_alloc.data;
    end
  end

  always_comb begin
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      o_entries[i].valid     = r_valid[i];
      o_entries[i].committed = r_committed[i];
      o_entries[i].addr      = r_addr[i];
      o_entries[i].size      = r_size[i];
      o_entries[i].data      = r_data[i];
    end
  end

  assign o_head_entry = o_entries[i_head_ptr];

endmodule

`default_nettype wire

//--- sq_fwd_unit.sv
// store to load forwarding
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module sq_fwd_unit
  import sq_pkg::*;
(
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire sq_ld_req_t           i_ld_req,
  input  wire sq_entry_vec_t        i_entries,
  input  wire logic [`SQ_PTR_W-1:0] i_head_ptr,
  output sq_fwd_resp_t              o_fwd
);

  logic [`SQ_BYTES-1:0]  ld_strb;
  logic [`SQ_BYTES-1:0]  ent_cover [`SQ_DEPTH];
  logic [`SQ_DATA_W-1:0] ent_data [`SQ_DEPTH];
  logic [`SQ_BYTES-1:0]  fwd_be;
  logic [`SQ_DATA_W-1:0] fwd_data;

  logic                  r_valid;
  logic                  r_hit;
  logic [`SQ_BYTES-1:0]  r_be;
  logic [`SQ_DATA_W-1:0] r_data;

  assign ld_strb = sq_strobe(i_ld_req.size, i_ld_req.addr.dw.ofs);

  // ----------------------------------------------------------
  // per entry match against the load doubleword
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      ent_data[i] = sq_align(i_entries[i].data, i_entries[i].addr.dw.ofs);
      ent_cover[i] = '0;
      if (i_entries[i].valid &&
          (i_entries[i].addr.dw.dw_idx == i_ld_req.addr.dw.dw_idx)) begin
        ent_cover[i] = ld_strb & sq_strobe(i_entries[i].size, i_entries[i].addr.dw.ofs);
      end
    end
  end

  // ----------------------------------------------------------
  // youngest covering store per byte
  // ----------------------------------------------------------
  always_comb begin
    logic [`SQ_PTR_W-1:0] idx;
    fwd_be   = '0;
    fwd_data = '0;
    idx      = i_head_ptr;
    // walk from head to tail so later hits override
    for (int k = 0; k < `SQ_DEPTH; k++) begin
      idx = i_head_ptr + k[`SQ_PTR_W-1:0];
      for (int b = 0; b < `SQ_BYTES; b++) begin
        if (ent_cover[idx][b]) begin
          fwd_be[b]          = 1'b1;
          fwd_data[b*8 +: 8] = ent_data[idx][b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ld_req.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ld_req.valid) begin
      r_hit  <= |fwd_be;
      r_be   <= fwd_be;
      r_data <= fwd_data;
    end
  end

  assign o_fwd.valid   = r_valid;
  assign o_fwd.hit     = r_hit;
  assign o_fwd.byte_en = r_be;
  assign o_fwd.data    = r_data;

endmodule

`default_nettype wire

//--- sq_pkg.sv
// store queue types
`default_nettype none

`include "sq_consts.svh"

package sq_pkg;

  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } sq_size_e;

  typedef enum logic {
    DRAIN_IDLE = 1'b0,
    DRAIN_WAIT = 1'b1
  } sq_drain_state_e;

  // doubleword view of an address
  typedef struct packed {
    logic [`SQ_ADDR_W-`SQ_OFS_W-1:0] dw_idx;
    logic [`SQ_OFS_W-1:0]            ofs;
  } sq_dw_addr_t;

  typedef union packed {
    logic [`SQ_ADDR_W-1:0] raw;
    sq_dw_addr_t           dw;
  } sq_addr_u;

  // data sits unshifted in the low bytes
  typedef struct packed {
    logic                  valid;
    sq_addr_u              addr;
    sq_size_e              size;
    logic [`SQ_DATA_W-1:0] data;
  } sq_alloc_t;

  typedef struct packed {
    logic                  valid;
    logic                  committed;
    sq_addr_u              addr;
    sq_size_e              size;
    logic [`SQ_DATA_W-1:0] data;
  } sq_entry_t;

  typedef sq_entry_t [`SQ_DEPTH-1:0] sq_entry_vec_t;

  typedef struct packed {
    logic     valid;
    sq_addr_u addr;
    sq_size_e size;
  } sq_ld_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  hit;
    logic [`SQ_BYTES-1:0]  byte_en;
    logic [`SQ_DATA_W-1:0] data;
  } sq_fwd_resp_t;

  typedef struct packed {
    logic                  valid;
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_BYTES-1:0]  byte_en;
    logic [`SQ_DATA_W-1:0] data;
  } sq_stbuf_req_t;

  // ----------------------------------------------------------
  // byte strobe and data alignment
  // ----------------------------------------------------------
  function automatic logic [`SQ_BYTES-1:0] sq_strobe(
    sq_size_e             size,
    logic [`SQ_OFS_W-1:0] ofs
  );
    logic [`SQ_BYTES-1:0] mask;
    for (int i = 0; i < `SQ_BYTES; i++) begin
      mask[i] = (i < (1 << int'(size)));
    end
    return mask << ofs;
  endfunction

  function automatic logic [`SQ_DATA_W-1:0] sq_align(
    logic [`SQ_DATA_W-1:0] data,
    logic [`SQ_OFS_W-1:0]  ofs
  );
    return data << {ofs, 3'b000};
  endfunction

endpackage

`default_nettype wire

//--- sq_ptr_counter.sv
// store queue pointers and counts
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module sq_ptr_counter (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire logic                 i_alloc_valid,
  input  wire logic                 i_commit,
  input  wire logic                 i_release,
  output logic                      o_alloc_en,
  output logic [`SQ_PTR_W-1:0]      o_tail_ptr,
  output logic [`SQ_PTR_W-1:0]      o_head_ptr,
  output logic [`SQ_PTR_W-1:0]      o_commit_ptr,
  output logic                      o_commit_en,
  output logic                      o_commit_pending,
  output logic                      o_full,
  output logic                      o_empty
);

  logic [`SQ_PTR_W-1:0] r_tail;
  logic [`SQ_PTR_W-1:0] r_head;
  // valid entries
  logic [`SQ_CNT_W-1:0] r_count;
  // committed entries not yet drained
  logic [`SQ_CNT_W-1:0] r_cmt_cnt;

  assign o_full  = (r_count == `SQ_DEPTH);
  assign o_empty = (r_count == '0);

  assign o_alloc_en = i_alloc_valid & ~o_full;

  // oldest uncommitted entry sits right after the committed run
  assign o_commit_ptr     = r_head + r_cmt_cnt[`SQ_PTR_W-1:0];
  assign o_commit_en      = i_commit & (r_count != r_cmt_cnt);
  assign o_commit_pending = (r_cmt_cnt != '0);

  assign o_tail_ptr = r_tail;
  assign o_head_ptr = r_head;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail    <= '0;
      r_head    <= '0;
      r_count   <= '0;
      r_cmt_cnt <= '0;
    end else begin
      if (o_alloc_en) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_release) begin
        r_head <= r_head + 1'b1;
      end

      // net change when events coincide
      case ({o_alloc_en, i_release})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase

      case ({o_commit_en, i_release})
        2'b10:   r_cmt_cnt <= r_cmt_cnt + 1'b1;
        2'b01:   r_cmt_cnt <= r_cmt_cnt - 1'b1;
        default: r_cmt_cnt <= r_cmt_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sq_stbuf_format.sv
// store buffer request formatter
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module sq_stbuf_format
  import sq_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_reset_n,
  input  wire logic      i_issue,
  input  wire sq_entry_t i_head_entry,
  output sq_stbuf_req_t  o_stbuf
);

  logic                  r_valid;
  logic [`SQ_ADDR_W-1:0] r_addr;
  logic [`SQ_BYTES-1:0]  r_byte_en;
  logic [`SQ_DATA_W-1:0] r_data;

  // request pulse follows the issue cycle
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue) begin
      r_addr    <= i_head_entry.addr.raw;
      r_byte_en <= sq_strobe(i_head_entry.size, i_head_entry.addr.dw.ofs);
      r_data    <= sq_align(i_head_entry.data, i_head_entry.addr.dw.ofs);
    end
  end

  assign o_stbuf.valid   = r_valid;
  assign o_stbuf.addr    = r_addr;
  assign o_stbuf.byte_en = r_byte_en;
  assign o_stbuf.data    = r_data;

endmodule

`default_nettype wire

//--- store_queue.f
+incdir+.
sq_pkg.sv
sq_ptr_counter.sv
sq_entry_array.sv
sq_drain_fsm.sv
sq_stbuf_format.sv
sq_fwd_unit.sv
store_queue.sv
tb_store_queue.sv

//--- store_queue.sv
// store queue top level
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module store_queue
  import sq_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_reset_n,
  input  wire sq_alloc_t  i_alloc,
  input  wire logic       i_commit,
  input  wire sq_ld_req_t i_ld_req,
  input  wire logic       i_stbuf_ack,
  output sq_fwd_resp_t    o_fwd,
  output sq_stbuf_req_t   o_stbuf,
  output logic            o_full,
  output logic            o_empty
);

  logic                 alloc_en;
  logic [`SQ_PTR_W-1:0] tail_ptr;
  logic [`SQ_PTR_W-1:0] head_ptr;
  logic [`SQ_PTR_W-1:0] commit_ptr;
  logic                 commit_en;
  logic                 commit_pending;
  sq_entry_vec_t        entries;
  sq_entry_t            head_entry;
  logic                 issue;
  logic                 drain_release;

  sq_ptr_counter u_ptr_counter (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_alloc_valid    (i_alloc.valid),
    .i_commit         (i_commit),
    .i_release        (drain_release),
    .o_alloc_en       (alloc_en),
    .o_tail_ptr       (tail_ptr),
    .o_head_ptr       (head_ptr),
    .o_commit_ptr     (commit_ptr),
    .o_commit_en      (commit_en),
    .o_commit_pending (commit_pending),
    .o_full           (o_full),
    .o_empty          (o_empty)
  );

  sq_entry_array u_entry_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc_en   (alloc_en),
    .i_alloc      (i_alloc),
    .i_tail_ptr   (tail_ptr),
    .i_commit_ptr (commit_ptr),
    .i_commit_en  (commit_en),
    .i_release    (drain_release),
    .i_head_ptr   (head_ptr),
    .o_entries    (entries),
    .o_head_entry (head_entry)
  );

  // drain path toward the store buffer
  sq_drain_fsm u_drain_fsm (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_commit_pending (commit_pending),
    .i_stbuf_ack      (i_stbuf_ack),
    .o_issue          (issue),
    .o_release        (drain_release)
  );

  sq_stbuf_format u_stbuf_format (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (issue),
    .i_head_entry (head_entry),
    .o_stbuf      (o_stbuf)
  );

  sq_fwd_unit u_fwd_unit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ld_req   (i_ld_req),
    .i_entries  (entries),
    .i_head_ptr (head_ptr),
    .o_fwd      (o_fwd)
  );

endmodule

`default_nettype wire

//--- tb_store_queue.sv
// store queue testbench
`timescale 1ns/1ps
`default_nettype none

`include "sq_consts.svh"

module tb_store_queue
  import sq_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_CYCLES   = 3000;

  logic          clk;
  logic          reset_n;
  sq_alloc_t     alloc;
  logic          commit;
  sq_ld_req_t    ld_req;
  logic          stbuf_ack;
  sq_fwd_resp_t  fwd;
  sq_stbuf_req_t stbuf;
  logic          full;
  logic          empty;

  // reference model with index 0 as the oldest store
  logic [31:0] m_addr [$];
  logic [1:0]  m_size [$];
  logic [63:0] m_data [$];
  bit          m_cmt [$];
  bit          m_wait;

  bit          exp_st_valid;
  logic [31:0] exp_st_addr;
  logic [7:0]  exp_st_be;
  logic [63:0] exp_st_data;
  bit          exp_fwd_valid;
  logic [7:0]  exp_fwd_be;
  logic [63:0] exp_fwd_data;

  int          ack_wait;
  bit          real_ack;
  bit          prev_real_ack;
  logic [31:0] rng_state;

  store_queue u_dut (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_alloc     (alloc),
    .i_commit    (commit),
    .i_ld_req    (ld_req),
    .i_stbuf_ack (stbuf_ack),
    .o_fwd       (fwd),
    .o_stbuf     (stbuf),
    .o_full      (full),
    .o_empty     (empty)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------------------------
  // random numbers and reference helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_range(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8]) % n;
  endfunction

  function automatic logic [7:0] byte_mask(input logic [1:0] size, input logic [2:0] ofs);
    logic [7:0] m;
    case (size)
      2'd0:    m = 8'h01;
      2'd1:    m = 8'h03;
      2'd2:    m = 8'h0f;
      default: m = 8'hff;
    endcase
    return m << ofs;
  endfunction

  function automatic logic [63:0] low_bytes(input logic [63:0] d, input logic [1:0] size);
    case (size)
      2'd0:    return d & 64'h0000_0000_0000_00ff;
      2'd1:    return d & 64'h0000_0000_0000_ffff;
      2'd2:    return d & 64'h0000_0000_ffff_ffff;
      default: return d;
    endcase
  endfunction

  // naturally aligned addresses in four doublewords so stores overlap
  function automatic logic [31:0] rand_addr(input logic [1:0] size);
    logic [2:0] ofs;
    ofs = 3'(rand_range(8));
    ofs = ofs & ~3'((1 << size) - 1);
    return 32'h0000_1000 + 32'(rand_range(4) * 8) + 32'(ofs);
  endfunction

  task automatic check(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      $display("error at time %0t: %s, got %0h, expected %0h", $time, what, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic predict_fwd(input logic [31:0] addr, input logic [1:0] size);
    logic [7:0]  ld_be;
    logic [7:0]  st_be;
    logic [63:0] st_data;
    ld_be        = byte_mask(size, addr[2:0]);
    exp_fwd_be   = '0;
    exp_fwd_data = '0;
    // younger stores overwrite older ones
    for (int i = 0; i < m_addr.size(); i++) begin
      if (m_addr[i][31:3] == addr[31:3]) begin
        st_be   = ld_be & byte_mask(m_size[i], m_addr[i][2:0]);
        st_data = m_data[i] << (8 * m_addr[i][2:0]);
        for (int b = 0; b < 8; b++) begin
          if (st_be[b]) begin
            exp_fwd_be[b]          = 1'b1;
            exp_fwd_data[b*8 +: 8] = st_data[b*8 +: 8];
          end
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // per cycle stimulus, checks and model update
  // ----------------------------------------------------------
  task automatic drive_inputs(input bit drain);
    logic [1:0] sz;
    alloc     = '0;
    ld_req    = '0;
    commit    = drain;
    stbuf_ack = 1'b0;
    real_ack  = 1'b0;
    if (!drain) begin
      if (rand_range(2) == 0) begin
        sz          = 2'(rand_range(4));
        alloc.valid = 1'b1;
        alloc.size  = sq_size_e'(sz);
        alloc.addr  = rand_addr(sz);
        alloc.data  = low_bytes({next_rand(), next_rand()}, sz);
      end
      commit = (rand_range(5) < 2);
      if (rand_range(2) == 0) begin
        sz           = 2'(rand_range(4));
        ld_req.valid = 1'b1;
        ld_req.size  = sq_size_e'(sz);
        ld_req.addr  = rand_addr(sz);
      end
    end
    if (ack_wait != 0) begin
      ack_wait--;
      if (ack_wait == 0) begin
        stbuf_ack = 1'b1;
        real_ack  = 1'b1;
      end
    end else if (!drain && !m_wait && rand_range(16) == 0) begin
      // stray ack with nothing in flight
      stbuf_ack = 1'b1;
    end
  endtask

  task automatic check_outputs();
    check(full, m_addr.size() == `SQ_DEPTH, "o_full");
    check(empty, m_addr.size() == 0, "o_empty");
    if (stbuf.valid) begin
      check(ack_wait != 0 || real_ack || prev_real_ack, 1'b0,
            "request while previous one in flight");
    end
    check(stbuf.valid, exp_st_valid, "o_stbuf.valid");
    if (exp_st_valid) begin
      check(stbuf.addr, exp_st_addr, "o_stbuf.addr");
      check(stbuf.byte_en, exp_st_be, "o_stbuf.byte_en");
      check(stbuf.data, exp_st_data, "o_stbuf.data");
    end
    check(fwd.valid, exp_fwd_valid, "o_fwd.valid");
    if (exp_fwd_valid) begin
      check(fwd.hit, |exp_fwd_be, "o_fwd.hit");
      check(fwd.byte_en, exp_fwd_be, "o_fwd.byte_en");
      check(fwd.data, exp_fwd_data, "o_fwd.data");
    end
  endtask

  task automatic update_model();
    bit alloc_ok;
    bit issue;
    bit release_head;
    alloc_ok      = alloc.valid && (m_addr.size() < `SQ_DEPTH);
    issue         = !m_wait && (m_cmt.size() != 0) && m_cmt[0];
    release_head  = m_wait && stbuf_ack;
    // lookup sees the queue as it is in this cycle
    exp_fwd_valid = ld_req.valid;
    if (ld_req.valid) begin
      predict_fwd(ld_req.addr, ld_req.size);
    end
    if (stbuf.valid) begin
      ack_wait = 1 + rand_range(4);
    end
    exp_st_valid = issue;
    if (issue) begin
      exp_st_addr = m_addr[0];
      exp_st_be   = byte_mask(m_size[0], m_addr[0][2:0]);
      exp_st_data = m_data[0] << (8 * m_addr[0][2:0]);
      m_wait      = 1'b1;
    end
    if (commit) begin
      for (int i = 0; i < m_cmt.size(); i++) begin
        if (!m_cmt[i]) begin
          m_cmt[i] = 1'b1;
          break;
        end
      end
    end
    if (release_head) begin
      void'(m_addr.pop_front());
      void'(m_size.pop_front());
      void'(m_data.pop_front());
      void'(m_cmt.pop_front());
      m_wait = 1'b0;
    end
    if (alloc_ok) begin
      m_addr.push_back(alloc.addr);
      m_size.push_back(alloc.size);
      m_data.push_back(alloc.data);
      m_cmt.push_back(1'b0);
    end
  endtask

  task automatic run_cycle(input bit drain);
    @(posedge clk);
    #2;
    drive_inputs(drain);
    @(negedge clk);
    check_outputs();
    update_model();
    prev_real_ack = real_ack;
  endtask

  initial begin
    rng_state     = 32'd58;
    reset_n       = 1'b0;
    alloc         = '0;
    commit        = 1'b0;
    ld_req        = '0;
    stbuf_ack     = 1'b0;
    m_wait        = 1'b0;
    exp_st_valid  = 1'b0;
    exp_fwd_valid = 1'b0;
    ack_wait      = 0;
    real_ack      = 1'b0;
    prev_real_ack = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    reset_n = 1'b1;
    @(negedge clk);
    check(stbuf.valid, 1'b0, "o_stbuf.valid after reset");
    check(fwd.valid, 1'b0, "o_fwd.valid after reset");
    check(full, 1'b0, "o_full after reset");
    check(empty, 1'b1, "o_empty after reset");

    repeat (N_CYCLES) run_cycle(1'b0);
    // commit and drain everything left
    while (m_addr.size() != 0 || m_wait || exp_st_valid || exp_fwd_valid || ack_wait != 0) begin
      run_cycle(1'b1);
    end
    // last release lands at the next edge, then outputs show an empty queue
    run_cycle(1'b1);
    check(empty, 1'b1, "o_empty after final drain");
    $display("Test passed");
    $finish;
  end

  // watchdog
  initial begin
    #(2 * N_CYCLES * CLK_PERIOD);
    $display("error at time %0t: the run timed out before the drain finished", $time);
    $display("Test failed");
    $fatal(1);
  end

endmodule

`default_nettype wire
